// ==== test/dcache_input.txt ====
// kind addr mask wdata expect, all hex
// kind 0 load, 1 load that must hit, 2 store, 3 uncached load, 4 write-back of addr's line
0 00000040 0 00000000 0bad0010
1 00000048 0 00000000 0bad0012
2 00000044 3 cafebeef 00000000
1 00000044 0 00000000 0badbeef
0 00002044 0 00000000 0bad0811
4 00000044 0 00000000 0badbeef
0 00000044 0 00000000 0badbeef
1 00000040 0 00000000 0bad0010
2 0000004c f 12345678 00000000
3 0000004c 0 00000000 0bad0013
1 0000004c 0 00000000 12345678
3 00002040 0 00000000 0bad0810
1 00000044 0 00000000 0badbeef
// random run over tags 0 to 2 and indices 2 to 5
2 00004088 f 11111111 00000000
0 000000c4 0 00000000 0bad0031
2 000000c4 4 00aa0000 00000000
0 00002088 0 00000000 0bad0822
4 00004088 0 00000000 11111111
0 00004088 0 00000000 11111111
2 00000144 1 000000ff 00000000
0 000040c4 0 00000000 0bad1031
4 000000c4 0 00000000 0baa0031
1 00000144 0 00000000 0bad00ff
0 000000c4 0 00000000 0baa0031
2 00002104 c beef0000 00000000
0 00004144 0 00000000 0bad1051
4 00000144 0 00000000 0bad00ff
0 00000144 0 00000000 0bad00ff
1 00002104 0 00000000 beef0841
0 0000010c 0 00000000 0bad0043
4 00002104 0 00000000 beef0841
0 00002104 0 00000000 beef0841
1 00004088 0 00000000 11111111

// ==== project.f ====
hw/dcache_pkg.sv
hw/line_store.sv
hw/miss_ctrl.sv
hw/writeback_ctrl.sv
hw/dcache_top.sv
test/mem_model.sv
test/tb_dcache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dcache
RTL_TOP   ?= dcache_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

RTL_SRCS = $(shell grep '^hw/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

    localparam int    PERIOD    = 8;
    localparam int    MAX_OPS   = 64;
    localparam int    FIELDS    = 5;
    localparam word_t MEM_XOR   = 32'h0bad0000;
    localparam string DATA_FILE = "test/dcache_input.txt";

    // Operation kinds in the data file
    localparam word_t K_LOAD_HIT = 32'd1;
    localparam word_t K_STORE    = 32'd2;
    localparam word_t K_UNCACHED = 32'd3;
    localparam word_t K_WB_CHECK = 32'd4;

    logic      clk;
    logic      rst;
    cpu_req_t  cpu_req;
    cpu_resp_t cpu_resp;
    rd_req_t   rd_req;
    logic      rd_ok;
    rd_beat_t  rd_beat;
    wr_req_t   wr_req;
    logic      wr_ok;
    wr_beat_t  wr_beat;
    logic      wready;
    logic      bvalid;
    logic      mem_fault;

    word_t vec [FIELDS*MAX_OPS];
    int    num_ops;
    int    cycles;
    int    cycle_limit;
    word_t wb_base;
    int    wb_n;
    word_t beat_addr_q [$];
    word_t beat_data_q [$];

    dcache_top uut (
        .clk      (clk),
        .rst      (rst),
        .cpu_req  (cpu_req),
        .cpu_resp (cpu_resp),
        .rd_req   (rd_req),
        .rd_ok    (rd_ok),
        .rd_beat  (rd_beat),
        .wr_req   (wr_req),
        .wr_ok    (wr_ok),
        .wr_beat  (wr_beat),
        .wready   (wready),
        .bvalid   (bvalid)
    );

    mem_model mem (
        .clk     (clk),
        .rst     (rst),
        .rd_req  (rd_req),
        .rd_ok   (rd_ok),
        .rd_beat (rd_beat),
        .wr_req  (wr_req),
        .wr_ok   (wr_ok),
        .wr_beat (wr_beat),
        .wready  (wready),
        .bvalid  (bvalid),
        .fault   (mem_fault)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    function automatic word_t mem_rule(input word_t a);
        return (a >> 2) ^ MEM_XOR;
    endfunction

    task automatic fail_stop();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_beat(input word_t got_addr, input word_t got_data,
                              input word_t exp_addr, input word_t exp_data);
        check_word("wr_req.addr", got_addr, exp_addr);
        check_word("wr_beat.data", got_data, exp_data);
    endtask

    // Records every accepted write-back beat with its address
    always @(posedge clk) begin
        if (wr_req.en && wr_ok) begin
            wb_base = wr_req.addr;
            wb_n = 0;
        end
        if (wr_beat.valid && wready) begin
            beat_addr_q.push_back(wb_base + word_t'(4 * wb_n));
            beat_data_q.push_back(wr_beat.data);
            wb_n++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout after %0d cycles", cycles);
            fail_stop();
        end
    end

    always @(negedge clk) begin
        if (mem_fault === 1'b1) begin
            $display("Memory model saw a broken write burst");
            fail_stop();
        end
    end

    task automatic run_op(input word_t kind, input addr_u addr, input byte_en_t mask,
                          input word_t wdata, input word_t exp_data);
        int    waited;
        word_t got;
        @(negedge clk);
        cpu_req.en       = 1'b1;
        cpu_req.uncached = kind == K_UNCACHED;
        cpu_req.mask     = kind == K_STORE ? mask : '0;
        cpu_req.addr     = addr;
        cpu_req.wdata    = wdata;
        waited = 0;
        @(posedge clk);
        while (!cpu_resp.ok) begin
            waited++;
            @(posedge clk);
        end
        got = cpu_resp.data;
        if (kind == K_LOAD_HIT && waited != 0) begin
            $display("Load at %h missed, ok came %0d cycles after enable", addr.raw, waited);
            fail_stop();
        end else begin
            check_word("cpu_resp.data", got, exp_data);
        end
    endtask

    // Old line from memory with only the merged word changed
    task automatic check_writeback(input addr_u addr, input word_t merged);
        word_t base;
        word_t a;
        word_t d;
        if (beat_addr_q.size() < LINE_WORDS) begin
            $display("Write-back burst missing, %0d beats recorded", beat_addr_q.size());
            fail_stop();
        end else begin
            base = addr.raw & ~word_t'(4 * LINE_WORDS - 1);
            for (int i = 0; i < LINE_WORDS; i++) begin
                a = base + word_t'(4 * i);
                d = (i == int'(addr.f.offset)) ? merged : mem_rule(a);
                check_beat(beat_addr_q.pop_front(), beat_data_q.pop_front(), a, d);
            end
        end
    endtask

    initial begin
        word_t kind;
        addr_u addr;
        rst     = 1'b1;
        cpu_req = '0;
        for (int i = 0; i < FIELDS*MAX_OPS; i++)
            vec[i] = '1;
        $readmemh(DATA_FILE, vec);
        num_ops = 0;
        while (num_ops < MAX_OPS && vec[FIELDS*num_ops] != '1)
            num_ops++;
        cycle_limit = num_ops * 200;
        if (num_ops == 0) begin
            $display("No operations found in %s", DATA_FILE);
            fail_stop();
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < num_ops; n++) begin
            kind     = vec[FIELDS*n];
            addr.raw = vec[FIELDS*n + 1];
            if (kind == K_WB_CHECK)
                check_writeback(addr, vec[FIELDS*n + 4]);
            else
                run_op(kind, addr, vec[FIELDS*n + 2][3:0], vec[FIELDS*n + 3],
                       vec[FIELDS*n + 4]);
        end
        @(negedge clk);
        cpu_req = '0;
        @(negedge clk);

        if (beat_addr_q.size() == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("%0d write-back beats were never expected", beat_addr_q.size());
            fail_stop();
        end
    end

endmodule

`default_nettype wire

// ==== test/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_model import dcache_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire rd_req_t  rd_req,
    output logic          rd_ok,
    output rd_beat_t      rd_beat,
    input  wire wr_req_t  wr_req,
    output logic          wr_ok,
    input  wire wr_beat_t wr_beat,
    output logic          wready,
    output logic          bvalid,
    output logic          fault
);

    localparam word_t SEED    = 32'h5c80;
    localparam word_t MEM_XOR = 32'h0bad0000;

    word_t wmem [word_t];   // Written words, keyed by word address
    word_t seed;
    logic [1:0] rnd;
    int rs;                 // Read side: 0 idle, 1 delay, 2 beats
    int ws;                 // Write side: 0 idle, 1 delay, 2 beats, 3 response
    int rwait;
    int wwait;
    int rbeat;
    int rlen;
    int wcnt;
    word_t raddr;
    word_t waddr;

    function automatic word_t lcg_next(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t read_word(input word_t a);
        if (wmem.exists(a >> 2))
            return wmem[a >> 2];
        return (a >> 2) ^ MEM_XOR;
    endfunction

    task automatic store_word(input word_t a, input byte_en_t m, input word_t d);
        word_t w;
        w = read_word(a);
        for (int b = 0; b < 4; b++) begin
            if (m[b])
                w[8*b +: 8] = d[8*b +: 8];
        end
        wmem[a >> 2] = w;
    endtask

    // Bus sampled on the rising edge
    always @(posedge clk) begin
        if (rst) begin
            rs = 0;
            ws = 0;
            fault = 1'b0;
        end else begin
            case (rs)
                0: if (rd_req.en) begin
                    raddr = rd_req.addr;
                    rlen  = rd_req.uncached ? 1 : LINE_WORDS;
                    rwait = int'(rnd);
                    rs    = 1;
                end
                1: if (rd_ok) begin
                    rbeat = 0;
                    rs    = 2;
                end else if (rwait > 0) begin
                    rwait--;
                end
                default: begin
                    rbeat++;
                    if (rbeat == rlen)
                        rs = 0;
                end
            endcase

            case (ws)
                0: if (wr_req.en) begin
                    waddr = wr_req.addr;
                    wwait = int'(rnd);
                    ws    = 1;
                end
                1: if (wr_ok) begin
                    wcnt = 0;
                    ws   = 2;
                end else if (wwait > 0) begin
                    wwait--;
                end
                2: if (wr_beat.valid && wready) begin
                    if (wr_beat.last != (wcnt == LINE_WORDS - 1)) begin
                        $display("Write beat %0d carries last flag %b", wcnt, wr_beat.last);
                        fault = 1'b1;
                    end
                    store_word(waddr + word_t'(4 * wcnt), wr_beat.mask, wr_beat.data);
                    wcnt++;
                    if (wcnt == LINE_WORDS)
                        ws = 3;
                end
                default: begin
                    if (wr_beat.valid) begin
                        $display("Write beat presented after the end of the burst");
                        fault = 1'b1;
                    end
                    if (bvalid)
                        ws = 0;
                end
            endcase
        end
    end

    // Responses change on the falling edge
    initial begin
        seed    = SEED;
        rnd     = '0;
        rd_ok   = 1'b0;
        rd_beat = '0;
        wr_ok   = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        forever begin
            @(negedge clk);
            seed    = lcg_next(seed);
            rnd     = seed[17:16];
            rd_ok   = rs == 1 && rwait == 0;
            rd_beat = '0;
            if (rs == 2) begin
                rd_beat.valid = 1'b1;
                rd_beat.last  = rbeat == rlen - 1;
                rd_beat.data  = read_word(raddr + word_t'(4 * rbeat));
            end
            wr_ok  = ws == 1 && wwait == 0;
            wready = ws == 2 && seed[19:18] != 2'b00;   // Roughly one stall in four
            bvalid = ws == 3;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,

    input  wire cpu_req_t  cpu_req,
    output cpu_resp_t      cpu_resp,

    output rd_req_t        rd_req,
    input  wire logic      rd_ok,
    input  wire rd_beat_t  rd_beat,

    output wr_req_t        wr_req,
    input  wire logic      wr_ok,
    output wr_beat_t       wr_beat,
    input  wire logic      wready,
    input  wire logic      bvalid
);

    logic  hit;
    logic  dirty;
    line_t cur_line;
    logic  store_en;
    logic  refill_en;
    line_t refill_line;
    logic  evict;
    logic  wb_idle;

    line_store u_store (
        .clk         (clk),
        .rst         (rst),
        .addr        (cpu_req.addr),
        .store_en    (store_en),
        .store_mask  (cpu_req.mask),
        .store_data  (cpu_req.wdata),
        .refill_en   (refill_en),
        .refill_line (refill_line),
        .hit         (hit),
        .dirty       (dirty),
        .line        (cur_line)
    );

    miss_ctrl u_miss (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_resp    (cpu_resp),
        .hit         (hit),
        .dirty       (dirty),
        .line        (cur_line),
        .store_en    (store_en),
        .refill_en   (refill_en),
        .refill_line (refill_line),
        .rd_req      (rd_req),
        .rd_ok       (rd_ok),
        .rd_beat     (rd_beat),
        .evict       (evict),
        .wb_idle     (wb_idle)
    );

    // Victim is whatever currently sits at the request index
    writeback_ctrl u_wb (
        .clk     (clk),
        .rst     (rst),
        .evict   (evict),
        .victim  (cur_line),
        .index   (cpu_req.addr.f.index),
        .wr_req  (wr_req),
        .wr_ok   (wr_ok),
        .wr_beat (wr_beat),
        .wready  (wready),
        .bvalid  (bvalid),
        .wb_idle (wb_idle)
    );

endmodule

`default_nettype wire

// ==== hw/writeback_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_ctrl import dcache_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               evict,
    input  wire line_t              victim,
    input  wire logic [INDEX_W-1:0] index,
    output wr_req_t                 wr_req,
    input  wire logic               wr_ok,
    output wr_beat_t                wr_beat,
    input  wire logic               wready,
    input  wire logic               bvalid,
    output logic                    wb_idle
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_SHAKE,
        W_STREAM,
        W_RESULT
    } wstate_t;

    wstate_t state, next;

    logic [OFFSET_W-1:0] out_cnt;
    addr_u victim_addr;

    // Old line address from the stored tag
    always_comb begin
        victim_addr.raw     = '0;
        victim_addr.f.tag   = victim.tag;
        victim_addr.f.index = index;
    end

    assign wb_idle = state == W_IDLE;

    always_ff @(posedge clk) begin
        if (rst)
            state <= W_IDLE;
        else
            state <= next;
    end

    always_ff @(posedge clk) begin
        if (rst || state != W_STREAM)
            out_cnt <= '0;
        else if (wready)
            out_cnt <= out_cnt + 1'b1;
    end

    always_comb begin
        next    = state;
        wr_req  = '0;
        wr_beat = '0;

        case (state)
            W_IDLE: begin
                if (evict) begin
                    wr_req = '{en: 1'b1, addr: victim_addr.raw};
                    next   = wr_ok ? W_STREAM : W_SHAKE;
                end
            end
            W_SHAKE: begin
                wr_req = '{en: 1'b1, addr: victim_addr.raw};
                if (wr_ok)
                    next = W_STREAM;
            end
            W_STREAM: begin
                wr_beat.valid = 1'b1;
                wr_beat.last  = &out_cnt;
                wr_beat.mask  = 4'b1111;
                wr_beat.data  = victim.words[out_cnt];
                if (wready && &out_cnt)
                    next = W_RESULT;
            end
            W_RESULT: begin
                if (bvalid)
                    next = W_IDLE;
            end
            default: next = W_IDLE;
        endcase
    end

    a_evict_when_idle: assert property (@(posedge clk) disable iff (rst)
        evict |-> state == W_IDLE);

endmodule

`default_nettype wire

// ==== hw/miss_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module miss_ctrl import dcache_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire cpu_req_t  cpu_req,
    output cpu_resp_t      cpu_resp,
    input  wire logic      hit,
    input  wire logic      dirty,
    input  wire line_t     line,
    output logic           store_en,
    output logic           refill_en,
    output line_t          refill_line,
    output rd_req_t        rd_req,
    input  wire logic      rd_ok,
    input  wire rd_beat_t  rd_beat,
    output logic           evict,
    input  wire logic      wb_idle
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RSHAKE,
        S_RECV,
        S_WBWAIT,
        S_REFILL,
        S_USHAKE,
        S_URET
    } state_t;

    state_t state, next;

    word_t [LINE_WORDS-1:0] rbuf;
    logic [OFFSET_W-1:0] beat_cnt;
    addr_u line_addr;
    logic is_store;

    assign is_store = cpu_req.mask != '0;

    // Line-aligned refill address
    always_comb begin
        line_addr = cpu_req.addr;
        line_addr.f.offset = '0;
        line_addr.f.byte_sel = '0;
    end

    assign refill_line.words = rbuf;
    assign refill_line.tag   = cpu_req.addr.f.tag;

    always_ff @(posedge clk) begin
        if (rst)
            state <= S_IDLE;
        else
            state <= next;
    end

    always_ff @(posedge clk) begin
        if (rst || state != S_RECV)
            beat_cnt <= '0;
        else if (rd_beat.valid)
            beat_cnt <= beat_cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (state == S_RECV && rd_beat.valid)
            rbuf[beat_cnt] <= rd_beat.data;
    end

    always_comb begin
        next      = state;
        cpu_resp  = '0;
        rd_req    = '0;
        store_en  = 1'b0;
        refill_en = 1'b0;
        evict     = 1'b0;

        case (state)
            S_IDLE: begin
                if (cpu_req.en && cpu_req.uncached) begin
                    rd_req = '{en: 1'b1, uncached: 1'b1, addr: cpu_req.addr.raw};
                    next   = rd_ok ? S_URET : S_USHAKE;
                end else if (cpu_req.en && hit) begin
                    cpu_resp.ok = 1'b1;
                    store_en    = is_store;
                    if (!is_store)
                        cpu_resp.data = line.words[cpu_req.addr.f.offset];
                end else if (cpu_req.en) begin
                    rd_req = '{en: 1'b1, uncached: 1'b0, addr: line_addr.raw};
                    evict  = dirty;     // Write-back runs alongside the read
                    next   = rd_ok ? S_RECV : S_RSHAKE;
                end
            end
            S_RSHAKE: begin
                rd_req = '{en: 1'b1, uncached: 1'b0, addr: line_addr.raw};
                if (rd_ok)
                    next = S_RECV;
            end
            S_RECV: begin
                if (rd_beat.valid && rd_beat.last)
                    next = wb_idle ? S_REFILL : S_WBWAIT;
            end
            S_WBWAIT: begin
                if (wb_idle)
                    next = S_REFILL;
            end
            S_REFILL: begin
                refill_en     = 1'b1;
                cpu_resp.ok   = !is_store;  // Store replays as a hit
                cpu_resp.data = is_store ? '0 : rbuf[cpu_req.addr.f.offset];
                next          = S_IDLE;
            end
            S_USHAKE: begin
                rd_req = '{en: 1'b1, uncached: 1'b1, addr: cpu_req.addr.raw};
                if (rd_ok)
                    next = S_URET;
            end
            S_URET: begin
                cpu_resp.ok   = rd_beat.valid;
                cpu_resp.data = rd_beat.data;
                if (rd_beat.valid && rd_beat.last)
                    next = S_IDLE;
            end
            default: next = S_IDLE;
        endcase
    end

    a_no_uncached_store: assert property (@(posedge clk) disable iff (rst)
        cpu_req.en && cpu_req.uncached |-> cpu_req.mask == '0);

    a_rd_addr_stable: assert property (@(posedge clk) disable iff (rst)
        rd_req.en && !rd_ok |=> rd_req.en && $stable(rd_req.addr));

endmodule

`default_nettype wire

// ==== hw/line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_store import dcache_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire addr_u    addr,
    input  wire logic     store_en,
    input  wire byte_en_t store_mask,
    input  wire word_t    store_data,
    input  wire logic     refill_en,
    input  wire line_t    refill_line,
    output logic          hit,
    output logic          dirty,
    output line_t         line
);

    line_t mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;

    logic [INDEX_W-1:0] idx;
    word_t merged;
    line_t wr_line;

    assign idx = addr.f.index;

    // Asynchronous read port
    assign line  = mem[idx];
    assign hit   = valid_q[idx] && (line.tag == addr.f.tag);
    assign dirty = dirty_q[idx];

    // Byte merge into the addressed word
    always_comb begin
        merged = line.words[addr.f.offset];
        for (int b = 0; b < 4; b++) begin
            if (store_mask[b])
                merged[8*b +: 8] = store_data[8*b +: 8];
        end
    end

    always_comb begin
        wr_line = line;
        if (refill_en) begin
            wr_line = refill_line;
        end else begin
            wr_line.words[addr.f.offset] = merged;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_en || store_en)
            mem[idx] <= wr_line;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (refill_en) begin
            valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dirty_q <= '0;
        end else if (refill_en) begin
            dirty_q[idx] <= 1'b0;   // Fresh line from memory
        end else if (store_en) begin
            dirty_q[idx] <= 1'b1;
        end
    end

    // Controller never overlaps a store with a refill
    a_store_refill_excl: assert property (@(posedge clk) disable iff (rst)
        !(store_en && refill_en));

endmodule

`default_nettype wire

// ==== hw/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    localparam int NUM_SETS   = 128;
    localparam int LINE_WORDS = 16;
    localparam int INDEX_W    = 7;
    localparam int OFFSET_W   = 4;
    localparam int TAG_W      = 19;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;

    // Same 32 bits, either flat or split into cache fields
    typedef union packed {
        word_t raw;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
            logic [1:0]          byte_sel;
        } f;
    } addr_u;

    // Tag in the low bits, word 0 right above it
    typedef struct packed {
        word_t [LINE_WORDS-1:0] words;
        logic [TAG_W-1:0]       tag;
    } line_t;

    typedef struct packed {
        logic     en;
        logic     uncached;
        byte_en_t mask;     // Zero for loads
        addr_u    addr;
        word_t    wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  ok;
        word_t data;
    } cpu_resp_t;

    typedef struct packed {
        logic  en;
        logic  uncached;
        word_t addr;
    } rd_req_t;

    typedef struct packed {
        logic  valid;
        logic  last;
        word_t data;
    } rd_beat_t;

    typedef struct packed {
        logic  en;
        word_t addr;
    } wr_req_t;

    typedef struct packed {
        logic     valid;
        logic     last;
        byte_en_t mask;
        word_t    data;
    } wr_beat_t;

endpackage

`default_nettype wire
